/* hw/pmp_pkg.sv */
//--------------------------------------------------------------------------
// PMP shared definitions
// Entry count, CSR address map, address types, the pmpcfg byte layout and
// the request bundles used by the CSR block and the access checker
//--------------------------------------------------------------------------
package pmp_pkg;

   //--------------------------------------------------------------------------
   // Sizing
   //--------------------------------------------------------------------------

   // Number of implemented PMP entries
   localparam int PMP_ENTRIES = 16;
   // Four cfg bytes per pmpcfg word
   localparam int CFG_GROUPS = PMP_ENTRIES / 4;
   // pmpaddr holds byte address bits 31:2
   localparam int WORD_ADDR_W = 30;

   //--------------------------------------------------------------------------
   // Basic vector types
   //--------------------------------------------------------------------------

   typedef logic [11:0]                 csr_addr_t;
   typedef logic [31:0]                 word_t;
   typedef logic [WORD_ADDR_W-1:0]      word_addr_t;
   typedef logic [$clog2(PMP_ENTRIES)-1:0] entry_idx_t;

   // CSR map, pmpcfg0..3 and pmpaddr0..15
   localparam csr_addr_t CSR_PMPCFG_BASE  = 12'h3A0;
   localparam csr_addr_t CSR_PMPADDR_BASE = 12'h3B0;

   // Writable cfg bits: L, A, X, W, R (bits 6:5 read as zero)
   localparam logic [7:0] CFG_WARL_MASK = 8'h9F;

   //--------------------------------------------------------------------------
   // Configuration byte
   //--------------------------------------------------------------------------

   // Address-matching mode, field A of the cfg byte
   typedef enum logic [1:0] {
      OFF   = 2'd0,
      TOR   = 2'd1,
      NA4   = 2'd2,
      NAPOT = 2'd3
   } pmp_mode_e;

   // Same bit order as the CSR byte, L in bit 7 and R in bit 0
   typedef struct packed {
      logic      lock;
      logic [1:0] rsvd;
      pmp_mode_e mode;
      logic      x;
      logic      w;
      logic      r;
   } pmp_cfg_t;

   //--------------------------------------------------------------------------
   // Access kind and privilege
   //--------------------------------------------------------------------------

   typedef logic [1:0] pmp_acc_t;
   localparam pmp_acc_t ACC_READ  = 2'd0;
   localparam pmp_acc_t ACC_WRITE = 2'd1;
   localparam pmp_acc_t ACC_EXEC  = 2'd2;

   // Only M and U exist here
   typedef logic pmp_priv_t;
   localparam pmp_priv_t PRIV_U = 1'b0;
   localparam pmp_priv_t PRIV_M = 1'b1;

   // CSR write request
   typedef struct packed {
      csr_addr_t addr;
      word_t     wdata;
   } csr_req_t;

   // Access check request, addr is a byte address
   typedef struct packed {
      word_t     addr;
      pmp_acc_t  acc;
      pmp_priv_t priv;
   } chk_req_t;

endpackage

/* hw/pmp_csr_ctl.sv */
//--------------------------------------------------------------------------
// PMP CSR block
// Holds pmpcfg and pmpaddr for all entries, applies WARL masking and the
// entry and TOR lock rules on writes, and returns registered read data
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module pmp_csr_ctl (
   input  logic                clk,
   input  logic                reset,
   input  logic                csr_we,
   input  pmp_pkg::csr_req_t   csr_wreq,
   input  logic                csr_re,
   input  pmp_pkg::csr_addr_t  csr_raddr,
   output logic                csr_rd_valid,
   output logic                csr_rd_hit,
   output pmp_pkg::word_t      csr_rdata,
   output pmp_pkg::pmp_cfg_t   pmp_cfg  [pmp_pkg::PMP_ENTRIES],
   output pmp_pkg::word_addr_t pmp_addr [pmp_pkg::PMP_ENTRIES]
);
   import pmp_pkg::*;

   // Write decode
   logic                   wr_cfg_sel;
   logic [1:0]             wr_cfg_group;
   logic                   wr_addr_sel;
   entry_idx_t             wr_addr_idx;

   // Lock bit of every entry
   logic [PMP_ENTRIES-1:0] entry_lock;

   // Register storage
   pmp_cfg_t               cfg_q  [PMP_ENTRIES];
   word_addr_t             addr_q [PMP_ENTRIES];

   // Read decode and mux
   logic                   rd_cfg_sel;
   logic [1:0]             rd_cfg_group;
   logic                   rd_addr_sel;
   entry_idx_t             rd_addr_idx;
   word_t                  rd_cfg_word;
   word_t                  rd_data_d;

   //--------------------------------------------------------------------------
   // Write address decode
   //--------------------------------------------------------------------------

   // pmpcfg0..3 only; higher groups belong to entries not built here
   assign wr_cfg_sel   = csr_we
                         & (csr_wreq.addr[11:4] == CSR_PMPCFG_BASE[11:4])
                         & (csr_wreq.addr[3:0] < CFG_GROUPS);
   assign wr_cfg_group = csr_wreq.addr[1:0];

   // pmpaddr0..15 fill the whole 0x3B0 block
   assign wr_addr_sel  = csr_we & (csr_wreq.addr[11:4] == CSR_PMPADDR_BASE[11:4]);
   assign wr_addr_idx  = csr_wreq.addr[3:0];

   //--------------------------------------------------------------------------
   // pmpcfg storage
   //--------------------------------------------------------------------------

   for (genvar i = 0; i < PMP_ENTRIES; i++) begin : g_cfg
      logic [7:0] raw_byte;
      logic [7:0] warl_byte;
      logic       cfg_wen;

      // Byte lane of this entry within its pmpcfg word
      assign raw_byte  = csr_wreq.wdata[8*(i%4) +: 8];

      // Bits 6:5 forced to zero
      // W only survives when R is also set
      assign warl_byte = raw_byte & CFG_WARL_MASK & {6'h3F, raw_byte[0], 1'b1};

      // A locked entry keeps its cfg until reset
      assign cfg_wen   = wr_cfg_sel & (wr_cfg_group == 2'(i / 4)) & ~entry_lock[i];

      assign entry_lock[i] = cfg_q[i].lock;

      always_ff @(posedge clk) begin
         if (reset) begin
            cfg_q[i] <= '0;
         end else if (cfg_wen) begin
            cfg_q[i] <= pmp_cfg_t'(warl_byte);
         end
      end
   end

   //--------------------------------------------------------------------------
   // pmpaddr storage
   //--------------------------------------------------------------------------

   for (genvar i = 0; i < PMP_ENTRIES; i++) begin : g_addr
      logic next_tor_lock;
      logic addr_lock;
      logic addr_wen;

      // Next entry in TOR uses this address as its lower bound
      if (i + 1 < PMP_ENTRIES) begin : g_next
         assign next_tor_lock = entry_lock[i+1] & (cfg_q[i+1].mode == TOR);
      end else begin : g_last
         assign next_tor_lock = 1'b0;
      end

      assign addr_lock = entry_lock[i] | next_tor_lock;
      assign addr_wen  = wr_addr_sel & (wr_addr_idx == entry_idx_t'(i)) & ~addr_lock;

      // Bits 31:30 of the write data are dropped, no storage behind them
      always_ff @(posedge clk) begin
         if (reset) begin
            addr_q[i] <= '0;
         end else if (addr_wen) begin
            addr_q[i] <= csr_wreq.wdata[WORD_ADDR_W-1:0];
         end
      end
   end

   assign pmp_cfg  = cfg_q;
   assign pmp_addr = addr_q;

   //--------------------------------------------------------------------------
   // CSR read
   //--------------------------------------------------------------------------

   assign rd_cfg_sel   = (csr_raddr[11:4] == CSR_PMPCFG_BASE[11:4])
                         & (csr_raddr[3:0] < CFG_GROUPS);
   assign rd_cfg_group = csr_raddr[1:0];
   assign rd_addr_sel  = csr_raddr[11:4] == CSR_PMPADDR_BASE[11:4];
   assign rd_addr_idx  = csr_raddr[3:0];

   // Entry 4g+3 in the top byte, entry 4g in the bottom byte
   assign rd_cfg_word = {cfg_q[{rd_cfg_group, 2'd3}],
                         cfg_q[{rd_cfg_group, 2'd2}],
                         cfg_q[{rd_cfg_group, 2'd1}],
                         cfg_q[{rd_cfg_group, 2'd0}]};

   always_comb begin
      if (rd_cfg_sel) begin
         rd_data_d = rd_cfg_word;
      end else if (rd_addr_sel) begin
         // Upper two bits read as zero
         rd_data_d = {{(32-WORD_ADDR_W){1'b0}}, addr_q[rd_addr_idx]};
      end else begin
         rd_data_d = '0;
      end
   end

   // Valid strobe one cycle after csr_re
   always_ff @(posedge clk) begin
      if (reset) begin
         csr_rd_valid <= 1'b0;
      end else begin
         csr_rd_valid <= csr_re;
      end
   end

   // Data and hit flag only move on a read
   always_ff @(posedge clk) begin
      if (csr_re) begin
         csr_rd_hit <= rd_cfg_sel | rd_addr_sel;
         csr_rdata  <= rd_data_d;
      end
   end

endmodule

/* hw/pmp_region_match.sv */
//--------------------------------------------------------------------------
// PMP region matcher
// Combinational address match of one entry for OFF, TOR, NA4 and NAPOT,
// passing the entry's permission bits and lock flag alongside the hit
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module pmp_region_match (
   input  pmp_pkg::pmp_cfg_t   cfg,
   input  pmp_pkg::word_addr_t addr,
   input  pmp_pkg::word_addr_t prev_addr,
   input  pmp_pkg::word_addr_t chk_addr,
   output logic                hit,
   output logic                perm_r,
   output logic                perm_w,
   output logic                perm_x,
   output logic                locked
);
   import pmp_pkg::*;

   logic       tor_hit;
   logic       na4_hit;
   logic       napot_hit;
   // Set where a NAPOT compare looks at the bit
   word_addr_t napot_care;
   // Still inside the run of trailing ones
   logic       ones_run;

   //--------------------------------------------------------------------------
   // Per-mode compares
   //--------------------------------------------------------------------------

   // TOR: prev_addr <= a < addr, empty when prev_addr >= addr
   assign tor_hit = (chk_addr >= prev_addr) && (chk_addr < addr);

   // NA4: exactly one word
   assign na4_hit = chk_addr == addr;

   // NAPOT mask
   // k trailing ones in addr give a region of 2^(k+1) words
   // Bits 0..k are don't care, i.e. the ones and the first zero
   always_comb begin
      napot_care = '1;
      ones_run   = 1'b1;
      for (int b = 0; b < WORD_ADDR_W; b++) begin
         if (ones_run) begin
            napot_care[b] = 1'b0;
         end
         ones_run = ones_run & addr[b];
      end
   end

   // All-ones addr leaves no care bits and covers the whole space
   assign napot_hit = ((chk_addr ^ addr) & napot_care) == '0;

   //--------------------------------------------------------------------------
   // Mode select
   //--------------------------------------------------------------------------

   always_comb begin
      case (cfg.mode)
         TOR:     hit = tor_hit;
         NA4:     hit = na4_hit;
         NAPOT:   hit = napot_hit;
         default: hit = 1'b0;
      endcase
   end

   // Permissions go out unqualified, the resolver only looks at
   // the entry it selects from the hit vector
   assign perm_r = cfg.r;
   assign perm_w = cfg.w;
   assign perm_x = cfg.x;
   assign locked = cfg.lock;

endmodule

/* hw/pmp_priority_resolve.sv */
//--------------------------------------------------------------------------
// PMP priority resolver
// Selects the lowest-index hitting entry, applies the M/U privilege and
// lock rules to its permission and registers the verdict
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module pmp_priority_resolve (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            chk_req,
   input  pmp_pkg::pmp_acc_t               acc,
   input  pmp_pkg::pmp_priv_t              priv,
   input  logic [pmp_pkg::PMP_ENTRIES-1:0] hit,
   input  logic [pmp_pkg::PMP_ENTRIES-1:0] perm_r,
   input  logic [pmp_pkg::PMP_ENTRIES-1:0] perm_w,
   input  logic [pmp_pkg::PMP_ENTRIES-1:0] perm_x,
   input  logic [pmp_pkg::PMP_ENTRIES-1:0] locked,
   output logic                            chk_valid,
   output logic                            chk_fault
);
   import pmp_pkg::*;

   logic       any_hit;
   entry_idx_t sel_idx;
   logic       sel_perm;
   logic       sel_locked;
   logic       fault_d;

   //--------------------------------------------------------------------------
   // Priority scan
   //--------------------------------------------------------------------------

   // Scan from the top so the lowest hitting index is written last
   always_comb begin
      any_hit = 1'b0;
      sel_idx = '0;
      for (int i = PMP_ENTRIES - 1; i >= 0; i--) begin
         if (hit[i]) begin
            any_hit = 1'b1;
            sel_idx = entry_idx_t'(i);
         end
      end
   end

   // Permission bit for this access kind
   always_comb begin
      case (acc)
         ACC_READ:  sel_perm = perm_r[sel_idx];
         ACC_WRITE: sel_perm = perm_w[sel_idx];
         ACC_EXEC:  sel_perm = perm_x[sel_idx];
         // Unknown kind has no permission bit
         default:   sel_perm = 1'b0;
      endcase
   end

   assign sel_locked = locked[sel_idx];

   //--------------------------------------------------------------------------
   // Verdict
   //--------------------------------------------------------------------------

   always_comb begin
      if (!any_hit) begin
         // No entry matched, only U-mode faults
         fault_d = (priv == PRIV_U);
      end else if ((priv == PRIV_M) && !sel_locked) begin
         // Unlocked entries do not restrict M-mode
         fault_d = 1'b0;
      end else begin
         fault_d = !sel_perm;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         chk_valid <= 1'b0;
         chk_fault <= 1'b0;
      end else begin
         chk_valid <= chk_req;
         chk_fault <= chk_req & fault_d;
      end
   end

endmodule

/* hw/pmp_unit.sv */
//--------------------------------------------------------------------------
// PMP unit top level
// CSR block, one region matcher per entry and the priority resolver
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module pmp_unit (
   input  logic               clk,
   input  logic               reset,
   input  logic               csr_we,
   input  pmp_pkg::csr_req_t  csr_wreq,
   input  logic               csr_re,
   input  pmp_pkg::csr_addr_t csr_raddr,
   output logic               csr_rd_valid,
   output logic               csr_rd_hit,
   output pmp_pkg::word_t     csr_rdata,
   input  logic               chk_req,
   input  pmp_pkg::chk_req_t  chk_in,
   output logic               chk_valid,
   output logic               chk_fault
);
   import pmp_pkg::*;

   // Register state fanned out to the matchers
   pmp_cfg_t               pmp_cfg  [PMP_ENTRIES];
   word_addr_t             pmp_addr [PMP_ENTRIES];

   // Word address of the access under check
   word_addr_t             chk_word_addr;

   // Per-entry match results
   logic [PMP_ENTRIES-1:0] hit;
   logic [PMP_ENTRIES-1:0] perm_r;
   logic [PMP_ENTRIES-1:0] perm_w;
   logic [PMP_ENTRIES-1:0] perm_x;
   logic [PMP_ENTRIES-1:0] locked;

   assign chk_word_addr = chk_in.addr[31:2];

   pmp_csr_ctl u_csr_ctl (
      .clk          (clk),
      .reset        (reset),
      .csr_we       (csr_we),
      .csr_wreq     (csr_wreq),
      .csr_re       (csr_re),
      .csr_raddr    (csr_raddr),
      .csr_rd_valid (csr_rd_valid),
      .csr_rd_hit   (csr_rd_hit),
      .csr_rdata    (csr_rdata),
      .pmp_cfg      (pmp_cfg),
      .pmp_addr     (pmp_addr)
   );

   //--------------------------------------------------------------------------
   // Region matchers
   //--------------------------------------------------------------------------

   for (genvar i = 0; i < PMP_ENTRIES; i++) begin : g_region
      word_addr_t prev_addr;

      // TOR lower bound, zero below entry 0
      if (i == 0) begin : g_base
         assign prev_addr = '0;
      end else begin : g_chain
         assign prev_addr = pmp_addr[i-1];
      end

      pmp_region_match u_match (
         .cfg       (pmp_cfg[i]),
         .addr      (pmp_addr[i]),
         .prev_addr (prev_addr),
         .chk_addr  (chk_word_addr),
         .hit       (hit[i]),
         .perm_r    (perm_r[i]),
         .perm_w    (perm_w[i]),
         .perm_x    (perm_x[i]),
         .locked    (locked[i])
      );
   end

   pmp_priority_resolve u_resolve (
      .clk       (clk),
      .reset     (reset),
      .chk_req   (chk_req),
      .acc       (chk_in.acc),
      .priv      (chk_in.priv),
      .hit       (hit),
      .perm_r    (perm_r),
      .perm_w    (perm_w),
      .perm_x    (perm_x),
      .locked    (locked),
      .chk_valid (chk_valid),
      .chk_fault (chk_fault)
   );

endmodule

/* tests/pmp_tb_model.svh */
//--------------------------------------------------------------------------
// PMP reference model
// Mirrors pmpcfg and pmpaddr from the CSR writes of the testbench and
// predicts read data and access verdicts from the PMP rules
//--------------------------------------------------------------------------

// Mirrored CSR state
pmp_cfg_t   mir_cfg  [PMP_ENTRIES];
word_addr_t mir_addr [PMP_ENTRIES];

// Reserved bits read as zero, W needs R
function automatic logic [7:0] warl_cfg_byte(input logic [7:0] b);
   logic [7:0] v;
   v = b;
   v[6:5] = 2'b00;
   if (!v[0]) begin
      v[1] = 1'b0;
   end
   return v;
endfunction

task automatic mirror_reset();
   for (int i = 0; i < PMP_ENTRIES; i++) begin
      mir_cfg[i]  = '0;
      mir_addr[i] = '0;
   end
endtask

task automatic mirror_csr_write(input csr_addr_t a, input word_t d);
   int   g;
   int   i;
   logic blocked;
   if (a >= CSR_PMPCFG_BASE && a < CSR_PMPCFG_BASE + 12'd4) begin
      g = int'(a - CSR_PMPCFG_BASE);
      // Each byte checks its own entry's lock
      for (int j = 0; j < 4; j++) begin
         if (!mir_cfg[4*g+j].lock) begin
            mir_cfg[4*g+j] = pmp_cfg_t'(warl_cfg_byte(d[8*j +: 8]));
         end
      end
   end else if (a >= CSR_PMPADDR_BASE && a < CSR_PMPADDR_BASE + 12'd16) begin
      i = int'(a - CSR_PMPADDR_BASE);
      blocked = mir_cfg[i].lock;
      // A locked TOR successor also freezes this address
      if (i < PMP_ENTRIES - 1) begin
         blocked = blocked | (mir_cfg[i+1].lock & (mir_cfg[i+1].mode == TOR));
      end
      if (!blocked) begin
         mir_addr[i] = d[29:0];
      end
   end
endtask

function automatic word_t expected_read(input csr_addr_t a, output logic hit);
   word_t v;
   int    g;
   v   = '0;
   hit = 1'b0;
   if (a >= CSR_PMPCFG_BASE && a < CSR_PMPCFG_BASE + 12'd4) begin
      hit = 1'b1;
      g = int'(a - CSR_PMPCFG_BASE);
      for (int j = 0; j < 4; j++) begin
         v[8*j +: 8] = mir_cfg[4*g+j];
      end
   end else if (a >= CSR_PMPADDR_BASE && a < CSR_PMPADDR_BASE + 12'd16) begin
      hit = 1'b1;
      v = {2'b00, mir_addr[int'(a - CSR_PMPADDR_BASE)]};
   end
   return v;
endfunction

function automatic logic entry_matches(input int i, input word_addr_t wa);
   word_addr_t lo;
   int         k;
   lo = '0;
   if (i > 0) begin
      lo = mir_addr[i-1];
   end
   case (mir_cfg[i].mode)
      TOR:     return (wa >= lo) && (wa < mir_addr[i]);
      NA4:     return wa == mir_addr[i];
      NAPOT: begin
         // k trailing ones, only the bits above k are compared
         k = 0;
         while (k < 30 && mir_addr[i][k]) begin
            k++;
         end
         return (wa >> (k + 1)) == (mir_addr[i] >> (k + 1));
      end
      default: return 1'b0;
   endcase
endfunction

function automatic logic expected_fault(input word_addr_t wa, input pmp_acc_t acc,
                                        input pmp_priv_t priv);
   for (int i = 0; i < PMP_ENTRIES; i++) begin
      if (entry_matches(i, wa)) begin
         if (priv == PRIV_M && !mir_cfg[i].lock) begin
            return 1'b0;
         end
         case (acc)
            ACC_READ:  return !mir_cfg[i].r;
            ACC_WRITE: return !mir_cfg[i].w;
            ACC_EXEC:  return !mir_cfg[i].x;
            default:   return 1'b1;
         endcase
      end
   end
   // Nothing matched
   return priv == PRIV_U;
endfunction

/* tests/pmp_tb.sv */
//--------------------------------------------------------------------------
// PMP unit testbench
// Directed CSR, lock, region, priority and privilege tests and a random
// stream of back-to-back checks, compared against a mirror model
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module pmp_tb;
   import pmp_pkg::*;

   // DUT ports
   logic      clk;
   logic      reset;
   logic      csr_we;
   csr_req_t  csr_wreq;
   logic      csr_re;
   csr_addr_t csr_raddr;
   logic      csr_rd_valid;
   logic      csr_rd_hit;
   word_t     csr_rdata;
   logic      chk_req;
   chk_req_t  chk_in;
   logic      chk_valid;
   logic      chk_fault;

   // Expected responses written together with the strobe
   word_t     exp_rdata;
   logic      exp_hit;
   logic      exp_fault;
   // Delayed one cycle to line up with the DUT outputs
   word_t     exp_rdata_q;
   logic      exp_hit_q;
   logic      exp_fault_q;
   // Strobes delayed by the fixed latency of one cycle
   logic      rd_req_q;
   logic      chk_req_q;

   string     test_name;
   int        rd_issued  = 0;
   int        rd_seen    = 0;
   int        chk_issued = 0;
   int        chk_seen   = 0;

   `include "pmp_tb_model.svh"

   pmp_unit dut (
      .clk          (clk),
      .reset        (reset),
      .csr_we       (csr_we),
      .csr_wreq     (csr_wreq),
      .csr_re       (csr_re),
      .csr_raddr    (csr_raddr),
      .csr_rd_valid (csr_rd_valid),
      .csr_rd_hit   (csr_rd_hit),
      .csr_rdata    (csr_rdata),
      .chk_req      (chk_req),
      .chk_in       (chk_in),
      .chk_valid    (chk_valid),
      .chk_fault    (chk_fault)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      exp_rdata_q <= exp_rdata;
      exp_hit_q   <= exp_hit;
      exp_fault_q <= exp_fault;
      rd_req_q    <= csr_re;
      chk_req_q   <= chk_req;
      // Response counts for the no-drop check at the end
      if (!reset && csr_rd_valid) begin
         rd_seen <= rd_seen + 1;
      end
      if (!reset && chk_valid) begin
         chk_seen <= chk_seen + 1;
      end
   end

   //--------------------------------------------------------------------------
   // Response checks
   //--------------------------------------------------------------------------

   rdata_check: assert property (@(posedge clk) disable iff (reset)
      csr_rd_valid |-> csr_rdata == exp_rdata_q)
      else report_value_error("csr_rdata", $sampled(exp_rdata_q), $sampled(csr_rdata));

   hit_check: assert property (@(posedge clk) disable iff (reset)
      csr_rd_valid |-> csr_rd_hit == exp_hit_q)
      else report_value_error("csr_rd_hit", word_t'($sampled(exp_hit_q)),
                              word_t'($sampled(csr_rd_hit)));

   fault_check: assert property (@(posedge clk) disable iff (reset)
      chk_valid |-> chk_fault == exp_fault_q)
      else report_value_error("chk_fault", word_t'($sampled(exp_fault_q)),
                              word_t'($sampled(chk_fault)));

   // Read data one cycle after csr_re and at no other time
   rd_valid_check: assert property (@(posedge clk) disable iff (reset)
      csr_rd_valid == rd_req_q)
      else report_value_error("csr_rd_valid", word_t'($sampled(rd_req_q)),
                              word_t'($sampled(csr_rd_valid)));

   // Verdict one cycle after chk_req and at no other time
   chk_valid_check: assert property (@(posedge clk) disable iff (reset)
      chk_valid == chk_req_q)
      else report_value_error("chk_valid", word_t'($sampled(chk_req_q)),
                              word_t'($sampled(chk_valid)));

   //--------------------------------------------------------------------------
   // Helpers
   //--------------------------------------------------------------------------

   task automatic abort_run();
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic report_value_error(input string sig, input word_t exp_v, input word_t act_v);
      $display("ERR %s %s: expected 0x%08h, actual 0x%08h", test_name, sig, exp_v, act_v);
      abort_run();
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset <= 1'b1;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      mirror_reset();
   endtask

   // Sampled on the falling edge away from the DUT updates
   task automatic wait_response(input logic for_read);
      logic seen;
      seen = 1'b0;
      for (int n = 0; n < 10 && !seen; n++) begin
         @(negedge clk);
         seen = for_read ? csr_rd_valid : chk_valid;
      end
      if (!seen) begin
         $display("timeout: no %s response in test %s", for_read ? "read" : "check",
                  test_name);
         abort_run();
      end
   endtask

   task automatic csr_write(input csr_addr_t a, input word_t d);
      @(posedge clk);
      csr_we         <= 1'b1;
      csr_wreq.addr  <= a;
      csr_wreq.wdata <= d;
      mirror_csr_write(a, d);
      @(posedge clk);
      csr_we <= 1'b0;
   endtask

   task automatic csr_read(input csr_addr_t a);
      logic  hit;
      word_t data;
      data = expected_read(a, hit);
      @(posedge clk);
      csr_re    <= 1'b1;
      csr_raddr <= a;
      exp_rdata <= data;
      exp_hit   <= hit;
      rd_issued++;
      @(posedge clk);
      csr_re <= 1'b0;
      wait_response(1'b1);
   endtask

   // One strobe without a wait so calls can run back to back
   task automatic issue_check(input word_t byte_addr, input pmp_acc_t acc,
                              input pmp_priv_t priv);
      @(posedge clk);
      chk_req      <= 1'b1;
      chk_in.addr  <= byte_addr;
      chk_in.acc   <= acc;
      chk_in.priv  <= priv;
      exp_fault    <= expected_fault(byte_addr[31:2], acc, priv);
      chk_issued++;
   endtask

   task automatic check_access(input word_t byte_addr, input pmp_acc_t acc,
                               input pmp_priv_t priv);
      issue_check(byte_addr, acc, priv);
      @(posedge clk);
      chk_req <= 1'b0;
      wait_response(1'b0);
   endtask

   // Read, write and execute on one word
   task automatic sweep_access(input word_t word_addr, input pmp_priv_t priv);
      check_access(word_addr << 2, ACC_READ, priv);
      check_access(word_addr << 2, ACC_WRITE, priv);
      check_access(word_addr << 2, ACC_EXEC, priv);
   endtask

   //--------------------------------------------------------------------------
   // Test sequence
   //--------------------------------------------------------------------------

   initial begin
      int    g;
      // Edges of the TOR, NA4 and NAPOT regions set up below
      word_t region_words[11];
      reset     = 1'b1;
      csr_we    = 1'b0;
      csr_wreq  = '0;
      csr_re    = 1'b0;
      csr_raddr = '0;
      chk_req   = 1'b0;
      chk_in    = '0;
      exp_rdata = '0;
      exp_hit   = 1'b0;
      exp_fault = 1'b0;
      region_words = '{32'h3F, 32'h40, 32'h7F, 32'h80, 32'hFF, 32'h100,
                       32'h101, 32'h1FF, 32'h200, 32'h207, 32'h208};
      void'($urandom(59944));

      // WARL readback with the lock bits kept clear
      test_name = "warl";
      apply_reset();
      for (int n = 0; n < 8; n++) begin
         g = $urandom_range(3, 0);
         csr_write(CSR_PMPCFG_BASE + csr_addr_t'(g), $urandom & 32'h7F7F_7F7F);
         csr_read(CSR_PMPCFG_BASE + csr_addr_t'(g));
         g = $urandom_range(15, 0);
         csr_write(CSR_PMPADDR_BASE + csr_addr_t'(g), $urandom);
         csr_read(CSR_PMPADDR_BASE + csr_addr_t'(g));
      end
      // Unmapped write must leave pmpcfg0 as it was
      csr_write(12'h3A4, 32'hFFFF_FFFF);
      csr_read(CSR_PMPCFG_BASE);
      csr_read(12'h3A4);
      csr_read(12'h300);
      csr_read(12'h3C0);

      // Entry 5 locked TOR with R and entry 9 locked NA4 with R
      test_name = "locks";
      apply_reset();
      csr_write(CSR_PMPADDR_BASE + 12'd5, 32'h100);
      csr_write(CSR_PMPCFG_BASE + 12'd1, 32'h0000_8900);
      csr_write(CSR_PMPCFG_BASE + 12'd2, 32'h0000_9100);
      csr_write(CSR_PMPCFG_BASE + 12'd1, 32'h0707_0707);
      csr_read(CSR_PMPCFG_BASE + 12'd1);
      for (int i = 4; i < 10; i++) begin
         csr_write(CSR_PMPADDR_BASE + csr_addr_t'(i), 32'h200 + i);
         csr_read(CSR_PMPADDR_BASE + csr_addr_t'(i));
      end

      // TOR 0x40..0x7F R, NA4 0x100 RW, NAPOT 0x200..0x207 X
      test_name = "regions";
      apply_reset();
      csr_write(CSR_PMPADDR_BASE + 12'd0, 32'h40);
      csr_write(CSR_PMPADDR_BASE + 12'd1, 32'h80);
      csr_write(CSR_PMPADDR_BASE + 12'd2, 32'h100);
      csr_write(CSR_PMPADDR_BASE + 12'd3, 32'h203);
      csr_write(CSR_PMPCFG_BASE, 32'h1C13_0900);
      foreach (region_words[n]) begin
         sweep_access(region_words[n], PRIV_U);
      end

      // Entry 2 denies 0x308, entry 4 allows 0x300..0x30F, entry 5 denies 0x304
      test_name = "priority";
      apply_reset();
      csr_write(CSR_PMPADDR_BASE + 12'd2, 32'h308);
      csr_write(CSR_PMPADDR_BASE + 12'd4, 32'h307);
      csr_write(CSR_PMPADDR_BASE + 12'd5, 32'h304);
      csr_write(CSR_PMPCFG_BASE, 32'h0010_0000);
      csr_write(CSR_PMPCFG_BASE + 12'd1, 32'h0000_101F);
      sweep_access(32'h300, PRIV_U);
      sweep_access(32'h304, PRIV_U);
      sweep_access(32'h308, PRIV_U);
      sweep_access(32'h30C, PRIV_U);

      // Same map before and after entry 2 is locked
      test_name = "privilege";
      sweep_access(32'h308, PRIV_M);
      sweep_access(32'h800, PRIV_M);
      sweep_access(32'h800, PRIV_U);
      csr_write(CSR_PMPCFG_BASE, 32'h0090_0000);
      sweep_access(32'h308, PRIV_M);
      sweep_access(32'h30C, PRIV_M);

      // Random map over the low 4 KB with one check per cycle
      test_name = "stream";
      apply_reset();
      for (int i = 0; i < PMP_ENTRIES; i++) begin
         csr_write(CSR_PMPADDR_BASE + csr_addr_t'(i), $urandom & 32'h3FF);
      end
      for (int i = 0; i < 4; i++) begin
         csr_write(CSR_PMPCFG_BASE + csr_addr_t'(i), $urandom);
      end
      for (int n = 0; n < 64; n++) begin
         issue_check($urandom & 32'hFFF, pmp_acc_t'($urandom_range(2, 0)),
                     pmp_priv_t'($urandom_range(1, 0)));
      end
      @(posedge clk);
      chk_req <= 1'b0;
      wait_response(1'b0);

      test_name = "end";
      repeat (3) @(posedge clk);
      if (rd_seen == rd_issued && chk_seen == chk_issued) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("response count wrong: reads %0d of %0d, checks %0d of %0d",
                  rd_seen, rd_issued, chk_seen, chk_issued);
         abort_run();
      end
   end

endmodule

/* pmp.f */
+incdir+tests
hw/pmp_pkg.sv
hw/pmp_csr_ctl.sv
hw/pmp_region_match.sv
hw/pmp_priority_resolve.sv
hw/pmp_unit.sv
tests/pmp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the PMP testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module pmp_tb -f pmp.f -o pmp_sim \
   && ./obj_dir/pmp_sim > sim.log 2>&1 \
   || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
